// File: include/u2_ctrl_cfg.svh
// Control plane configuration for the system bus
// Address map, setting addresses, reset values and compatibility number
`ifndef U2_CTRL_CFG_SVH
`define U2_CTRL_CFG_SVH

// Number of top address bits used for slave decoding
`define U2_DECODE_W 6

// Region codes on adr[15:10]
// Settings bus at 0xD400
`define U2_SETTINGS_BASE 6'b110101
// Interrupt controller at 0xD800
`define U2_PIC_BASE 6'b110110
// Status readback at 0xCC00
`define U2_STATUS_BASE 6'b110011

// Setting register addresses, word address adr[9:2]
`define SR_CLK 8'd0
`define SR_SER 8'd1
`define SR_ADC 8'd2
`define SR_LED 8'd3
`define SR_PHY 8'd4
`define SR_LED_SRC 8'd8

// LED source after reset, hardware drives bits 4:1
`define LED_SRC_RESET 8'h1E
// Bumped when the register map changes incompatibly
`define COMPAT_NUM 32'd3

`endif

// File: src/u2_ctrl_pkg.sv
// Shared types of the control plane
// Bus, setting and interrupt vector widths
package u2_ctrl_pkg;

   // Byte address on the system bus
   typedef logic [15:0] wb_adr_t;

   // Bus data word
   typedef logic [31:0] wb_dat_t;

   // Setting register address, bus word address bits 9:2
   typedef logic [7:0] set_addr_t;

   // Setting payload
   typedef logic [31:0] set_dat_t;

   // One control byte (clock, serdes, ADC, LED)
   typedef logic [7:0] ctrl_byte_t;

   // Interrupt lines into the PIC
   typedef logic [15:0] irq_t;

endpackage

// File: src/wb_slave_if.sv
// Wishbone slave port between the decoder and one slave
`timescale 1ns/1ps

interface wb_slave_if;

   // Request side, driven by the decoder
   u2_ctrl_pkg::wb_adr_t adr;
   u2_ctrl_pkg::wb_dat_t dat_w;
   logic                 we;
   logic                 stb;

   // Response side, driven by the slave
   u2_ctrl_pkg::wb_dat_t dat_r;
   logic                 ack;

   modport master (output adr, dat_w, we, stb, input dat_r, ack);

   modport slave (input adr, dat_w, we, stb, output dat_r, ack);

endinterface

// File: src/wb_decoder.sv
// Single master address decoder for the control bus
// Routes strobes, muxes read data, errors on unmapped regions
`timescale 1ns/1ps
`include "u2_ctrl_cfg.svh"

module wb_decoder (
   input  logic                 wb_clk,
   input  logic                 wb_rst,
   input  u2_ctrl_pkg::wb_adr_t wb_adr_i,
   input  u2_ctrl_pkg::wb_dat_t wb_dat_i,
   input  logic                 wb_we_i,
   input  logic                 wb_stb_i,
   output u2_ctrl_pkg::wb_dat_t wb_dat_o,
   output logic                 wb_ack_o,
   output logic                 wb_err_o,
   wb_slave_if.master           set_bus,
   wb_slave_if.master           pic_bus,
   wb_slave_if.master           stat_bus
);

   logic [`U2_DECODE_W-1:0] region;
   logic                    hit_set;
   logic                    hit_pic;
   logic                    hit_stat;
   logic                    unmapped;
   logic                    err_q;

   //////////////////////////////////////////////////////////////////////
   // Region decode
   assign region   = wb_adr_i[15 -: `U2_DECODE_W];
   assign hit_set  = (region == `U2_SETTINGS_BASE);
   assign hit_pic  = (region == `U2_PIC_BASE);
   assign hit_stat = (region == `U2_STATUS_BASE);
   assign unmapped = ~(hit_set | hit_pic | hit_stat);

   // Shared request lines, strobe only to the hit slave
   assign set_bus.adr    = wb_adr_i;
   assign set_bus.dat_w  = wb_dat_i;
   assign set_bus.we     = wb_we_i;
   assign set_bus.stb    = wb_stb_i & hit_set;
   assign pic_bus.adr    = wb_adr_i;
   assign pic_bus.dat_w  = wb_dat_i;
   assign pic_bus.we     = wb_we_i;
   assign pic_bus.stb    = wb_stb_i & hit_pic;
   assign stat_bus.adr   = wb_adr_i;
   assign stat_bus.dat_w = wb_dat_i;
   assign stat_bus.we    = wb_we_i;
   assign stat_bus.stb   = wb_stb_i & hit_stat;

   //////////////////////////////////////////////////////////////////////
   // Response path
   // Only one slave is strobed at a time, so at most one ack
   assign wb_ack_o = set_bus.ack | pic_bus.ack | stat_bus.ack;

   always_comb begin
      if (set_bus.ack) begin
         wb_dat_o = set_bus.dat_r;
      end else if (pic_bus.ack) begin
         wb_dat_o = pic_bus.dat_r;
      end else if (stat_bus.ack) begin
         wb_dat_o = stat_bus.dat_r;
      end else begin
         wb_dat_o = '0;
      end
   end

   // Unmapped cycle, one err pulse then wait for stb to drop
   always_ff @(posedge wb_clk) begin
      if (wb_rst) begin
         err_q <= 1'b0;
      end else begin
         err_q <= wb_stb_i & unmapped & ~err_q;
      end
   end

   assign wb_err_o = err_q;

endmodule

// File: src/settings_bus.sv
// Settings bus slave
// Turns bus writes into a one-cycle setting strobe with address and data
`timescale 1ns/1ps

module settings_bus (
   input  logic                   wb_clk,
   input  logic                   wb_rst,
   wb_slave_if.slave              bus,
   output logic                   set_stb_o,
   output u2_ctrl_pkg::set_addr_t set_addr_o,
   output u2_ctrl_pkg::set_dat_t  set_data_o
);

   logic new_cycle;

   // First cycle of a strobe, ack not yet given
   assign new_cycle = bus.stb & ~bus.ack;

   // Single-cycle ack, strobe for writes only
   always_ff @(posedge wb_clk) begin
      if (wb_rst) begin
         bus.ack   <= 1'b0;
         set_stb_o <= 1'b0;
      end else begin
         bus.ack   <= new_cycle;
         set_stb_o <= new_cycle & bus.we;
      end
   end

   // Word address and payload, valid with set_stb_o
   always_ff @(posedge wb_clk) begin
      if (new_cycle & bus.we) begin
         set_addr_o <= bus.adr[9:2];
         set_data_o <= bus.dat_w;
      end
   end

   // Write-only slave
   assign bus.dat_r = '0;

endmodule

// File: src/setting_bank.sv
// Setting registers for clock, serdes, ADC, PHY and LED controls
// Also selects each LED between hardware status and software value
`timescale 1ns/1ps
`include "u2_ctrl_cfg.svh"

module setting_bank (
   input  logic                    wb_clk,
   input  logic                    wb_rst,
   input  logic                    set_stb_i,
   input  u2_ctrl_pkg::set_addr_t  set_addr_i,
   input  u2_ctrl_pkg::set_dat_t   set_data_i,
   input  logic                    run_tx_i,
   input  logic                    run_rx_i,
   input  logic                    clk_status_i,
   input  logic                    serdes_link_up_i,
   output u2_ctrl_pkg::ctrl_byte_t clock_outs_o,
   output u2_ctrl_pkg::ctrl_byte_t serdes_outs_o,
   output u2_ctrl_pkg::ctrl_byte_t adc_outs_o,
   output u2_ctrl_pkg::ctrl_byte_t leds_o,
   output logic                    phy_reset_o
);

   u2_ctrl_pkg::ctrl_byte_t led_sw;
   u2_ctrl_pkg::ctrl_byte_t led_src;
   u2_ctrl_pkg::ctrl_byte_t led_hw;

   //////////////////////////////////////////////////////////////////////
   // Setting registers
   // Loaded on the edge after set_stb_i, low byte only
   always_ff @(posedge wb_clk) begin
      if (wb_rst) begin
         clock_outs_o  <= '0;
         serdes_outs_o <= '0;
         adc_outs_o    <= '0;
         led_sw        <= '0;
         phy_reset_o   <= 1'b0;
         led_src       <= `LED_SRC_RESET;
      end else if (set_stb_i) begin
         case (set_addr_i)
            `SR_CLK:     clock_outs_o  <= set_data_i[7:0];
            `SR_SER:     serdes_outs_o <= set_data_i[7:0];
            `SR_ADC:     adc_outs_o    <= set_data_i[7:0];
            `SR_LED:     led_sw        <= set_data_i[7:0];
            // PHY reset keeps bit 0 only
            `SR_PHY:     phy_reset_o   <= set_data_i[0];
            `SR_LED_SRC: led_src       <= set_data_i[7:0];
            // Other addresses belong to nobody here
            default: begin
            end
         endcase
      end
   end

   //////////////////////////////////////////////////////////////////////
   // LED source mux
   // Hardware status word, bit 0 and bits 7:5 have no source
   assign led_hw = {3'b000, run_tx_i, run_rx_i, clk_status_i, serdes_link_up_i, 1'b0};

   // Per bit, 1 = hardware, 0 = software
   assign leds_o = (led_src & led_hw) | (~led_src & led_sw);

endmodule

// File: src/pic.sv
// Programmable interrupt controller
// Edge/level and polarity per line, mask, pending, priority index
`timescale 1ns/1ps

module pic (
   input  logic              wb_clk,
   input  logic              wb_rst,
   wb_slave_if.slave         bus,
   input  u2_ctrl_pkg::irq_t irq_i,
   output logic              int_o
);

   u2_ctrl_pkg::irq_t edge_sel;
   u2_ctrl_pkg::irq_t polarity;
   u2_ctrl_pkg::irq_t mask;
   u2_ctrl_pkg::irq_t pending;
   u2_ctrl_pkg::irq_t irq_q;
   u2_ctrl_pkg::irq_t act_d;
   u2_ctrl_pkg::irq_t active;
   u2_ctrl_pkg::irq_t clr;
   u2_ctrl_pkg::irq_t live;
   logic [31:0]       prio;
   logic [2:0]        word;
   logic              wr;

   assign word = bus.adr[4:2];
   assign wr   = bus.stb & bus.we & ~bus.ack;

   //////////////////////////////////////////////////////////////////////
   // Control registers and ack
   always_ff @(posedge wb_clk) begin
      if (wb_rst) begin
         bus.ack  <= 1'b0;
         edge_sel <= '0;
         polarity <= '0;
         mask     <= '0;
      end else begin
         bus.ack <= bus.stb & ~bus.ack;
         if (wr && word == 3'd0) edge_sel <= bus.dat_w[15:0];
         if (wr && word == 3'd1) polarity <= bus.dat_w[15:0];
         if (wr && word == 3'd2) mask     <= bus.dat_w[15:0];
      end
   end

   //////////////////////////////////////////////////////////////////////
   // Pending logic
   // Inputs registered once, then polarity applied
   assign active = irq_q ^ polarity;
   // Write 1 to clear, edge lines only
   assign clr = (wr && word == 3'd3) ? bus.dat_w[15:0] : '0;

   always_ff @(posedge wb_clk) begin
      if (wb_rst) begin
         irq_q   <= '0;
         act_d   <= '0;
         pending <= '0;
      end else begin
         irq_q   <= irq_i;
         act_d   <= active;
         // Level lines follow, edge lines latch rising edges
         pending <= (~edge_sel & active) |
                    (edge_sel & ((pending & ~clr) | (active & ~act_d)));
      end
   end

   assign live  = pending & ~mask;
   assign int_o = |live;

   // Lowest unmasked pending line wins, bit 31 flags none
   always_comb begin
      prio = 32'h8000_0000;
      for (int i = 15; i >= 0; i--) begin
         if (live[i]) prio = 32'(i);
      end
   end

   // Readback
   always_comb begin
      case (word)
         3'd0:    bus.dat_r = {16'h0000, edge_sel};
         3'd1:    bus.dat_r = {16'h0000, polarity};
         3'd2:    bus.dat_r = {16'h0000, mask};
         3'd3:    bus.dat_r = {16'h0000, pending};
         3'd4:    bus.dat_r = prio;
         default: bus.dat_r = '0;
      endcase
   end

endmodule

// File: src/status_readback.sv
// Read-only status words
// Free-running cycle counter, compatibility number, irq and strap readback
`timescale 1ns/1ps
`include "u2_ctrl_cfg.svh"

module status_readback (
   input  logic              wb_clk,
   input  logic              wb_rst,
   wb_slave_if.slave         bus,
   input  u2_ctrl_pkg::irq_t irq_i,
   input  logic              sim_mode_i,
   input  logic [3:0]        clock_divider_i
);

   logic [31:0] cycle_count;

   // Counts every wb_clk cycle out of reset
   always_ff @(posedge wb_clk) begin
      if (wb_rst) begin
         cycle_count <= '0;
      end else begin
         cycle_count <= cycle_count + 32'd1;
      end
   end

   // Registered single-cycle ack, writes are ignored
   always_ff @(posedge wb_clk) begin
      if (wb_rst) begin
         bus.ack <= 1'b0;
      end else begin
         bus.ack <= bus.stb & ~bus.ack;
      end
   end

   // Word select on adr[4:2], adr held until ack
   always_comb begin
      case (bus.adr[4:2])
         3'd0:    bus.dat_r = cycle_count;
         3'd1:    bus.dat_r = `COMPAT_NUM;
         3'd2:    bus.dat_r = {16'h0000, irq_i};
         3'd3:    bus.dat_r = {sim_mode_i, 27'd0, clock_divider_i};
         default: bus.dat_r = '0;
      endcase
   end

endmodule

// File: src/u2_ctrl_top.sv
// Control plane top level
// System bus decoder, settings, interrupt controller and status readback
`timescale 1ns/1ps

module u2_ctrl_top (
   input  logic                    wb_clk,
   input  logic                    wb_rst,
   // Host bus
   input  u2_ctrl_pkg::wb_adr_t    wb_adr_i,
   input  u2_ctrl_pkg::wb_dat_t    wb_dat_i,
   input  logic                    wb_we_i,
   input  logic                    wb_stb_i,
   output u2_ctrl_pkg::wb_dat_t    wb_dat_o,
   output logic                    wb_ack_o,
   output logic                    wb_err_o,
   // Status and interrupt inputs
   input  u2_ctrl_pkg::irq_t       irq_i,
   input  logic                    run_tx_i,
   input  logic                    run_rx_i,
   input  logic                    clk_status_i,
   input  logic                    serdes_link_up_i,
   input  logic                    sim_mode_i,
   input  logic [3:0]              clock_divider_i,
   output logic                    int_o,
   output u2_ctrl_pkg::ctrl_byte_t leds_o,
   // Board control pins
   output logic                    clock_ready_o,
   output logic [1:0]              clk_en_o,
   output logic [1:0]              clk_sel_o,
   output logic                    ser_enable_o,
   output logic                    ser_prbsen_o,
   output logic                    ser_loopen_o,
   output logic                    ser_rx_en_o,
   output logic                    adc_oe_a_o,
   output logic                    adc_on_a_o,
   output logic                    adc_oe_b_o,
   output logic                    adc_on_b_o,
   output logic                    phy_resetn_o
);

   logic                    set_stb;
   u2_ctrl_pkg::set_addr_t  set_addr;
   u2_ctrl_pkg::set_dat_t   set_data;
   u2_ctrl_pkg::ctrl_byte_t clock_outs;
   u2_ctrl_pkg::ctrl_byte_t serdes_outs;
   u2_ctrl_pkg::ctrl_byte_t adc_outs;
   logic                    phy_reset;

   // One slave port per mapped region
   wb_slave_if set_bus ();
   wb_slave_if pic_bus ();
   wb_slave_if stat_bus ();

   wb_decoder wb_decoder (.wb_clk, .wb_rst, .wb_adr_i, .wb_dat_i, .wb_we_i, .wb_stb_i,
      .wb_dat_o, .wb_ack_o, .wb_err_o, .set_bus, .pic_bus, .stat_bus);

   settings_bus settings_bus (.wb_clk, .wb_rst, .bus(set_bus),
      .set_stb_o(set_stb), .set_addr_o(set_addr), .set_data_o(set_data));

   setting_bank setting_bank (.wb_clk, .wb_rst, .set_stb_i(set_stb), .set_addr_i(set_addr),
      .set_data_i(set_data), .run_tx_i, .run_rx_i, .clk_status_i, .serdes_link_up_i,
      .clock_outs_o(clock_outs), .serdes_outs_o(serdes_outs), .adc_outs_o(adc_outs),
      .leds_o, .phy_reset_o(phy_reset));

   pic pic (.wb_clk, .wb_rst, .bus(pic_bus), .irq_i, .int_o);

   status_readback status_readback (.wb_clk, .wb_rst, .bus(stat_bus), .irq_i,
      .sim_mode_i, .clock_divider_i);

   //////////////////////////////////////////////////////////////////////
   // Control bytes to pins
   assign {clock_ready_o, clk_en_o, clk_sel_o} = clock_outs[4:0];
   assign {ser_enable_o, ser_prbsen_o, ser_loopen_o, ser_rx_en_o} = serdes_outs[3:0];
   assign {adc_oe_a_o, adc_on_a_o, adc_oe_b_o, adc_on_b_o} = adc_outs[3:0];
   // PHY reset pin is active low
   assign phy_resetn_o = ~phy_reset;

endmodule

// File: test/u2_ctrl_properties.sv
// Handshake checks on the bus decoder
// Bound to every wb_decoder instance
`timescale 1ns/1ps

module u2_ctrl_properties (
   input logic wb_clk,
   input logic wb_rst,
   input logic wb_stb_i,
   input logic wb_ack_o,
   input logic wb_err_o
);

   // Number of failed handshake checks
   int fail_count = 0;

   // Never both responses at once
   ack_err_excl: assert property (@(posedge wb_clk) disable iff (wb_rst)
      !(wb_ack_o && wb_err_o))
      else begin
         $error("ack and err high in the same cycle");
         fail_count++;
      end

   // Responses only inside a strobed cycle
   resp_in_cycle: assert property (@(posedge wb_clk) disable iff (wb_rst)
      (wb_ack_o || wb_err_o) |-> wb_stb_i)
      else begin
         $error("ack or err without stb");
         fail_count++;
      end

   // New cycle answered within 2 cycles
   resp_in_time: assert property (@(posedge wb_clk) disable iff (wb_rst)
      $rose(wb_stb_i) |-> ##[1:2] (wb_ack_o || wb_err_o))
      else begin
         $error("no ack or err within 2 cycles of stb");
         fail_count++;
      end

endmodule

// File: test/tb_u2_ctrl.sv
// Testbench for the control plane top level
// Replays bus patterns, then checks LEDs, interrupts and status words
`timescale 1ns/1ps
`include "u2_ctrl_cfg.svh"

module tb_u2_ctrl;

   logic                    wb_clk = 1'b0;
   logic                    wb_rst;
   u2_ctrl_pkg::wb_adr_t    wb_adr;
   u2_ctrl_pkg::wb_dat_t    wb_dat_w;
   u2_ctrl_pkg::wb_dat_t    wb_dat_r;
   logic                    wb_we;
   logic                    wb_stb;
   logic                    wb_ack;
   logic                    wb_err;
   u2_ctrl_pkg::irq_t       irq;
   logic                    run_tx;
   logic                    run_rx;
   logic                    clk_status;
   logic                    link_up;
   logic                    sim_mode;
   logic [3:0]              clk_div;
   logic                    int_line;
   u2_ctrl_pkg::ctrl_byte_t leds;
   // {phy_resetn, adc[3:0], serdes[3:0], clock[4:0]}
   logic [13:0]             pins;
   // Expected setting registers
   u2_ctrl_pkg::ctrl_byte_t exp_clk;
   u2_ctrl_pkg::ctrl_byte_t exp_ser;
   u2_ctrl_pkg::ctrl_byte_t exp_adc;
   logic                    exp_phy;

   always #10 wb_clk = ~wb_clk;

   u2_ctrl_top dut0 (.wb_clk, .wb_rst, .wb_adr_i(wb_adr), .wb_dat_i(wb_dat_w), .wb_we_i(wb_we),
      .wb_stb_i(wb_stb), .wb_dat_o(wb_dat_r), .wb_ack_o(wb_ack), .wb_err_o(wb_err),
      .irq_i(irq), .run_tx_i(run_tx), .run_rx_i(run_rx), .clk_status_i(clk_status),
      .serdes_link_up_i(link_up), .sim_mode_i(sim_mode), .clock_divider_i(clk_div),
      .int_o(int_line), .leds_o(leds), .clock_ready_o(pins[4]), .clk_en_o(pins[3:2]),
      .clk_sel_o(pins[1:0]), .ser_enable_o(pins[8]), .ser_prbsen_o(pins[7]),
      .ser_loopen_o(pins[6]), .ser_rx_en_o(pins[5]), .adc_oe_a_o(pins[12]),
      .adc_on_a_o(pins[11]), .adc_oe_b_o(pins[10]), .adc_on_b_o(pins[9]),
      .phy_resetn_o(pins[13]));

   bind wb_decoder u2_ctrl_properties props0 (.wb_clk, .wb_rst, .wb_stb_i, .wb_ack_o, .wb_err_o);

   task automatic fail_run(input string msg);
      $display("%s", msg);
      $display("SOME TESTS FAILED");
      $fatal(1, "Run stopped");
   endtask

   task automatic check(input string what, input logic [31:0] got, input logic [31:0] exp);
      if (got !== exp) begin
         fail_run($sformatf("** Error at %0t ns: %s: got %h, expected %h", $time, what, got, exp));
      end
   endtask

   // Next value of the 32-bit LCG
   function automatic logic [31:0] lcg(input logic [31:0] s);
      return s * 32'd1664525 + 32'd1013904223;
   endfunction

   // Hardware status LEDs as the board wires them
   function automatic logic [7:0] hw_leds();
      return {3'b000, run_tx, run_rx, clk_status, link_up, 1'b0};
   endfunction

   // Expected LEDs, bit by bit from the source select
   function automatic logic [7:0] led_expect(input logic [7:0] src, input logic [7:0] sw);
      logic [7:0] hw;
      logic [7:0] res;
      hw = hw_leds();
      for (int b = 0; b < 8; b++) begin
         res[b] = src[b] ? hw[b] : sw[b];
      end
      return res;
   endfunction

   //////////////////////////////////////////////////////////////////////
   // Bus master
   // One cycle, stb held until ack or err, dropped one cycle later
   task automatic bus_cycle(input logic we, input u2_ctrl_pkg::wb_adr_t adr,
         input u2_ctrl_pkg::wb_dat_t dat, output u2_ctrl_pkg::wb_dat_t rd, output logic err);
      int waited;
      @(negedge wb_clk);
      wb_adr   = adr;
      wb_dat_w = dat;
      wb_we    = we;
      wb_stb   = 1'b1;
      waited   = 0;
      do begin
         @(negedge wb_clk);
         waited++;
         if (waited > 10) begin
            fail_run($sformatf("Timeout at %0t ns: no ack or err from address %h", $time, adr));
         end
      end while (!(wb_ack || wb_err));
      check("ack and err together", 32'(wb_ack & wb_err), 32'd0);
      rd  = wb_dat_r;
      err = wb_err;
      @(negedge wb_clk);
      wb_stb = 1'b0;
      wb_we  = 1'b0;
   endtask

   task automatic bus_write(input u2_ctrl_pkg::wb_adr_t adr, input u2_ctrl_pkg::wb_dat_t dat);
      u2_ctrl_pkg::wb_dat_t rd;
      logic err;
      bus_cycle(1'b1, adr, dat, rd, err);
      check($sformatf("err on write to %h", adr), 32'(err), 32'd0);
      // Settings region updates the expected pins
      if (adr[15:10] == `U2_SETTINGS_BASE) begin
         case (adr[9:2])
            `SR_CLK: exp_clk = dat[7:0];
            `SR_SER: exp_ser = dat[7:0];
            `SR_ADC: exp_adc = dat[7:0];
            `SR_PHY: exp_phy = dat[0];
            default: begin
            end
         endcase
      end
   endtask

   task automatic bus_read(input u2_ctrl_pkg::wb_adr_t adr, output u2_ctrl_pkg::wb_dat_t rd);
      logic err;
      bus_cycle(1'b0, adr, 32'd0, rd, err);
      check($sformatf("err on read from %h", adr), 32'(err), 32'd0);
   endtask

   task automatic read_check(input u2_ctrl_pkg::wb_adr_t adr, input u2_ctrl_pkg::wb_dat_t exp);
      u2_ctrl_pkg::wb_dat_t rd;
      bus_read(adr, rd);
      check($sformatf("read from %h", adr), rd, exp);
   endtask

   task automatic expect_err(input logic we, input u2_ctrl_pkg::wb_adr_t adr,
         input u2_ctrl_pkg::wb_dat_t dat);
      u2_ctrl_pkg::wb_dat_t rd;
      logic err;
      bus_cycle(we, adr, dat, rd, err);
      check($sformatf("err from unmapped %h", adr), 32'(err), 32'd1);
   endtask

   task automatic check_pins();
      check("control pins", 32'(pins), 32'({~exp_phy, exp_adc[3:0], exp_ser[3:0], exp_clk[4:0]}));
   endtask

   initial begin
      int          fd;
      int          n;
      string       line;
      byte         op;
      logic [31:0] a;
      logic [31:0] d;
      logic [31:0] rd;
      logic [31:0] rd2;
      logic [31:0] rnd;
      logic [7:0]  src;
      logic [7:0]  sw;
      wb_rst   = 1'b1;
      wb_adr   = '0;
      wb_dat_w = '0;
      wb_we    = 1'b0;
      wb_stb   = 1'b0;
      irq      = '0;
      run_tx   = 1'b1;
      run_rx   = 1'b0;
      clk_status = 1'b1;
      link_up  = 1'b1;
      sim_mode = 1'b0;
      clk_div  = 4'd0;
      exp_clk  = '0;
      exp_ser  = '0;
      exp_adc  = '0;
      exp_phy  = 1'b0;
      rnd      = 32'h1a3262bc;
      repeat (8) @(negedge wb_clk);
      wb_rst = 1'b0;

      // Reset state
      @(negedge wb_clk);
      check_pins();
      check("LEDs after reset", leds, hw_leds() & 8'h1E);
      check("int_o after reset", int_line, 1'b0);

      // Pattern replay, pins rechecked after every operation
      fd = $fopen("test/u2_ctrl_patterns.txt", "r");
      if (fd == 0) begin
         fail_run("Could not open test/u2_ctrl_patterns.txt");
      end
      while (!$feof(fd)) begin
         n = $fgets(line, fd);
         if (n > 0 && $sscanf(line, "%c %h %h", op, a, d) == 3) begin
            case (op)
               "W": bus_write(a[15:0], d);
               "R": read_check(a[15:0], d);
               "E": expect_err(1'b1, a[15:0], d);
               default: fail_run($sformatf("Unknown pattern operation in line: %s", line));
            endcase
            check_pins();
         end
      end
      $fclose(fd);

      //////////////////////////////////////////////////////////////////////
      // LED source mux with random values
      for (int i = 0; i < 20; i++) begin
         rnd = lcg(rnd);
         src = rnd[31:24];
         bus_write(16'hD400 | 16'(`SR_LED_SRC << 2), {24'd0, src});
         rnd = lcg(rnd);
         sw  = rnd[31:24];
         bus_write(16'hD400 | 16'(`SR_LED << 2), {24'd0, sw});
         rnd = lcg(rnd);
         {run_tx, run_rx, clk_status, link_up} = rnd[31:28];
         @(negedge wb_clk);
         check("LED mux", leds, led_expect(src, sw));
      end

      //////////////////////////////////////////////////////////////////////
      // Interrupt controller
      // Level lines 3 and 5, then mask and priority
      irq = 16'h0028;
      repeat (2) @(negedge wb_clk);
      check("level line raises int_o", int_line, 1'b1);
      read_check(16'hD810, 32'd3);
      bus_write(16'hD808, 32'h0000_0028);
      check("masked line drops int_o", int_line, 1'b0);
      read_check(16'hD810, 32'h8000_0000);
      bus_write(16'hD808, 32'd0);
      irq = 16'h0000;
      // Line 0 active low
      bus_write(16'hD804, 32'h0000_0001);
      repeat (2) @(negedge wb_clk);
      check("inverted low line raises int_o", int_line, 1'b1);
      read_check(16'hD810, 32'd0);
      bus_write(16'hD804, 32'd0);
      repeat (2) @(negedge wb_clk);
      check("polarity restored", int_line, 1'b0);
      // Edge line 2, one-cycle pulse
      bus_write(16'hD800, 32'h0000_0004);
      irq = 16'h0004;
      @(negedge wb_clk);
      irq = 16'h0000;
      repeat (4) @(negedge wb_clk);
      check("edge pulse stays pending", int_line, 1'b1);
      read_check(16'hD80C, 32'h0000_0004);
      bus_write(16'hD80C, 32'h0000_0004);
      check("edge pending cleared", int_line, 1'b0);
      read_check(16'hD80C, 32'd0);
      bus_write(16'hD800, 32'd0);

      //////////////////////////////////////////////////////////////////////
      // Status readback
      rnd      = lcg(rnd);
      sim_mode = 1'b1;
      clk_div  = rnd[27:24];
      irq      = rnd[15:0];
      read_check(16'hCC0C, {sim_mode, 27'd0, clk_div});
      read_check(16'hCC08, {16'd0, irq});
      irq = 16'h0000;
      bus_read(16'hCC00, rd);
      bus_read(16'hCC00, rd2);
      check("cycle counter increases", 32'(rd2 > rd), 32'd1);

      // Unmapped read
      expect_err(1'b0, 16'h0000, 32'd0);
      check_pins();

      if (dut0.wb_decoder.props0.fail_count != 0) begin
         fail_run("A bus handshake assertion failed during the run");
      end else begin
         $display("ALL TESTS PASSED");
         $finish;
      end
   end

endmodule

// File: test/u2_ctrl_patterns.txt
# Control bus patterns, one operation per line
# op (W write, R read and compare, E expect error), hex address, hex data
W D400 0000001F
W D404 0000000A
W D408 00000005
W D410 00000001
W D414 000000FF
W D7FC FFFFFFFF
R D400 00000000
W D400 00000012
W D404 00000005
W D408 0000000A
W D410 00000000
E 0000 0000001F
E 1234 FFFFFFFF
W D808 0000FFFF
R D808 0000FFFF
W D808 00000000
R D808 00000000
R D810 80000000
R CC04 00000003
R CC10 00000000

// File: all.f
+incdir+include
src/u2_ctrl_pkg.sv
src/wb_slave_if.sv
src/wb_decoder.sv
src/settings_bus.sv
src/setting_bank.sv
src/pic.sv
src/status_readback.sv
src/u2_ctrl_top.sv
test/u2_ctrl_properties.sv
test/tb_u2_ctrl.sv

// File: Bender.yml
package:
  name: u2_ctrl

sources:
  - include_dirs:
      - include
    files:
      - src/u2_ctrl_pkg.sv
      - src/wb_slave_if.sv
      - src/wb_decoder.sv
      - src/settings_bus.sv
      - src/setting_bank.sv
      - src/pic.sv
      - src/status_readback.sv
      - src/u2_ctrl_top.sv
  - target: test
    include_dirs:
      - include
    files:
      - test/u2_ctrl_properties.sv
      - test/tb_u2_ctrl.sv
